// ==== dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cache geometry

// number of ways per set
`define DCACHE_NWAY 2

// sets per way
`define DCACHE_NSET 256

// bytes per line to match one memory-bus beat
`define DCACHE_LINE_BYTES 16

// CPU and memory byte address
`define DCACHE_ADDR_WIDTH 32

// victim selector register width
`define DCACHE_LFSR_WIDTH 16

`endif

// ==== dcache_ctrl.sv ====
`include "dcache_config.svh"
`timescale 1ns/10ps

module dcache_ctrl
    import dcache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          req_valid,
    input  logic                          req_write,
    input  logic                          req_uncached,
    input  logic [`DCACHE_ADDR_WIDTH-1:0] req_addr,
    input  logic [3:0]                    req_wstrb,
    input  word_t                         req_wdata,
    output logic                          req_ready,
    output logic                          resp_valid,
    output word_t                         resp_rdata,

    output logic                          rd_req,
    output mem_type_e                     rd_type,
    output logic [`DCACHE_ADDR_WIDTH-1:0] rd_addr,
    input  logic                          rd_rdy,
    input  logic                          ret_valid,
    input  logic                          ret_last,
    input  line_t                         ret_data,

    output logic                          wr_req,
    output mem_type_e                     wr_type,
    output logic [`DCACHE_ADDR_WIDTH-1:0] wr_addr,
    output line_strb_t                    wr_wstrb,
    output line_t                         wr_data,
    input  logic                          wr_rdy,

    input  way_mask_t                     way_hit,
    input  line_t                         hit_line,
    input  way_mask_t                     victim,
    output index_t                        rd_index,
    output index_t                        wr_index,
    output tag_t                          cmp_tag,
    output tag_t                          wr_tag,
    output way_mask_t                     wr_way,
    output line_strb_t                    wr_strb,
    output line_t                         wr_line
);

    localparam int AW = `DCACHE_ADDR_WIDTH;

    dcache_state_e state, next_state;

    // accepted request
    logic          buf_write;
    logic          buf_uncached;
    logic [AW-1:0] buf_addr;
    logic [3:0]    buf_wstrb;
    word_t         buf_wdata;

    logic [1:0]    word_sel;
    logic          hit;
    logic          ret_done;
    logic          cached_read_hit;
    line_t         lane_data;
    line_strb_t    lane_strb;

    assign req_ready = (state == IDLE);  // one request in flight

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            buf_write    <= req_write;
            buf_uncached <= req_uncached;
            buf_addr     <= req_addr;
            buf_wstrb    <= req_wstrb;
            buf_wdata    <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign word_sel        = buf_addr[OFFSET_W-1:2];
    assign hit             = |way_hit;
    assign ret_done        = ret_valid && ret_last;
    assign cached_read_hit = !buf_write && !buf_uncached && hit;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (req_valid) next_state = LOOKUP;
            end
            LOOKUP: begin
                if (buf_write) begin
                    next_state = WRITE;  // hit merge happens here, bus write next
                end else if (cached_read_hit) begin
                    next_state = IDLE;
                end else begin
                    next_state = MISS;   // cached miss or uncached read
                end
            end
            MISS: begin
                if (rd_rdy) next_state = REFILL;
            end
            REFILL: begin
                if (ret_done) next_state = IDLE;
            end
            WRITE: begin
                if (wr_rdy) next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // arrays see the incoming index in IDLE so LOOKUP has data
    assign rd_index = (state == IDLE) ? req_addr[OFFSET_W +: INDEX_W]
                                      : buf_addr[OFFSET_W +: INDEX_W];
    assign wr_index = buf_addr[OFFSET_W +: INDEX_W];
    assign cmp_tag  = buf_addr[AW-1 -: TAG_W];
    assign wr_tag   = buf_addr[AW-1 -: TAG_W];

    // word and strobe moved into lane addr[3:2]
    assign lane_data = line_t'(buf_wdata) << {word_sel, 5'd0};
    assign lane_strb = line_strb_t'(buf_wstrb) << {word_sel, 2'd0};

    always_comb begin
        wr_way  = '0;
        wr_strb = lane_strb;
        wr_line = lane_data;
        if (state == LOOKUP && buf_write && !buf_uncached) begin
            wr_way = way_hit;  // zero on miss so no allocate
        end else if (state == REFILL && ret_done && !buf_uncached) begin
            wr_way  = victim;
            wr_strb = '1;
            wr_line = ret_data;
        end
    end

    // read channel
    assign rd_req = (state == MISS);

    always_comb begin
        if (buf_uncached) begin
            rd_type = MEM_WORD;
            rd_addr = buf_addr;
        end else begin
            rd_type = MEM_LINE;
            rd_addr = {buf_addr[AW-1:OFFSET_W], {OFFSET_W{1'b0}}};  // line aligned
        end
    end

    // write channel carries one word
    assign wr_req   = (state == WRITE);
    assign wr_type  = MEM_WORD;
    assign wr_addr  = buf_addr;
    assign wr_wstrb = lane_strb;
    assign wr_data  = lane_data;

    assign resp_valid = (state == LOOKUP && cached_read_hit)
                     || (state == REFILL && ret_done)
                     || (state == WRITE && wr_rdy);

    assign resp_rdata = (state == REFILL) ? ret_data[{word_sel, 5'd0} +: 32]
                                          : hit_line[{word_sel, 5'd0} +: 32];

    a_one_channel: assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req));

    a_rd_addr_hold: assert property (@(posedge clk) disable iff (rst)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr) && $stable(rd_type));

    // a response ends the request and frees the cache
    a_resp_idle: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> state != IDLE ##1 state == IDLE);

endmodule

// ==== dcache_data_array.sv ====
`include "dcache_config.svh"
`timescale 1ns/10ps

module dcache_data_array
    import dcache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  index_t     rd_index,
    input  way_mask_t  way_hit,
    input  index_t     wr_index,
    input  way_mask_t  wr_way,
    input  line_strb_t wr_strb,
    input  line_t      wr_line,
    output line_t      hit_line
);

    line_t line_mem [`DCACHE_NWAY][`DCACHE_NSET];
    line_t rd_line [`DCACHE_NWAY];

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_NWAY; w++) begin
            for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
                if (wr_way[w] && wr_strb[b]) begin
                    line_mem[w][wr_index][b*8 +: 8] <= wr_line[b*8 +: 8];
                end
            end
            rd_line[w] <= line_mem[w][rd_index];
        end
    end

    // way_hit is one-hot or zero, so an OR of masked lines is the mux
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DCACHE_NWAY; w++) begin
            if (way_hit[w]) hit_line = hit_line | rd_line[w];
        end
    end

    // refill names one victim, a write hit one matching way
    a_wr_way_onehot: assert property (@(posedge clk) $onehot0(wr_way));

endmodule

// ==== dcache_pkg.sv ====
`include "dcache_config.svh"

package dcache_pkg;

    // address is tag | index | offset
    localparam int OFFSET_W = $clog2(`DCACHE_LINE_BYTES);
    localparam int INDEX_W  = $clog2(`DCACHE_NSET);
    localparam int TAG_W    = `DCACHE_ADDR_WIDTH - INDEX_W - OFFSET_W;
    localparam int LINE_W   = `DCACHE_LINE_BYTES * 8;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,  // arrays valid for buffered index
        MISS,    // read request on the bus
        REFILL,  // waiting for the return beat
        WRITE    // write-through on the bus
    } dcache_state_e;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_NWAY-1:0] way_mask_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [31:0] word_t;

endpackage

// ==== dcache_tag_array.sv ====
`include "dcache_config.svh"
`timescale 1ns/10ps

module dcache_tag_array
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  index_t    rd_index,
    input  tag_t      cmp_tag,
    input  index_t    wr_index,
    input  way_mask_t wr_way,
    input  tag_t      wr_tag,
    output way_mask_t way_hit
);

    tag_t tag_mem [`DCACHE_NWAY][`DCACHE_NSET];
    logic [`DCACHE_NSET-1:0] valid_bits [`DCACHE_NWAY];

    tag_t rd_tag [`DCACHE_NWAY];
    way_mask_t rd_valid;

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_NWAY; w++) begin
            if (wr_way[w]) tag_mem[w][wr_index] <= wr_tag;
            rd_tag[w] <= tag_mem[w][rd_index];  // old value on same-edge write
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DCACHE_NWAY; w++) begin
                valid_bits[w] <= '0;
            end
            rd_valid <= '0;
        end else begin
            for (int w = 0; w < `DCACHE_NWAY; w++) begin
                if (wr_way[w]) valid_bits[w][wr_index] <= 1'b1;
                rd_valid[w] <= valid_bits[w][rd_index];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_NWAY; w++) begin
            way_hit[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
        end
    end

    // a line must never be resident in two ways
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule

// ==== dcache_top.sv ====
`include "dcache_config.svh"
`timescale 1ns/10ps

module dcache_top
    import dcache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          req_valid,
    input  logic                          req_write,
    input  logic                          req_uncached,
    input  logic [`DCACHE_ADDR_WIDTH-1:0] req_addr,
    input  logic [3:0]                    req_wstrb,
    input  word_t                         req_wdata,
    output logic                          req_ready,
    output logic                          resp_valid,
    output word_t                         resp_rdata,

    output logic                          rd_req,
    output mem_type_e                     rd_type,
    output logic [`DCACHE_ADDR_WIDTH-1:0] rd_addr,
    input  logic                          rd_rdy,
    input  logic                          ret_valid,
    input  logic                          ret_last,
    input  line_t                         ret_data,

    output logic                          wr_req,
    output mem_type_e                     wr_type,
    output logic [`DCACHE_ADDR_WIDTH-1:0] wr_addr,
    output line_strb_t                    wr_wstrb,
    output line_t                         wr_data,
    input  logic                          wr_rdy
);

    index_t     rd_index;
    index_t     wr_index;
    tag_t       cmp_tag;
    tag_t       wr_tag;
    way_mask_t  way_hit;
    way_mask_t  wr_way;
    way_mask_t  victim;
    line_strb_t wr_strb;
    line_t      wr_line;
    line_t      hit_line;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_uncached (req_uncached),
        .req_addr     (req_addr),
        .req_wstrb    (req_wstrb),
        .req_wdata    (req_wdata),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .resp_rdata   (resp_rdata),
        .rd_req       (rd_req),
        .rd_type      (rd_type),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .wr_req       (wr_req),
        .wr_type      (wr_type),
        .wr_addr      (wr_addr),
        .wr_wstrb     (wr_wstrb),
        .wr_data      (wr_data),
        .wr_rdy       (wr_rdy),
        .way_hit      (way_hit),
        .hit_line     (hit_line),
        .victim       (victim),
        .rd_index     (rd_index),
        .wr_index     (wr_index),
        .cmp_tag      (cmp_tag),
        .wr_tag       (wr_tag),
        .wr_way       (wr_way),
        .wr_strb      (wr_strb),
        .wr_line      (wr_line)
    );

    dcache_tag_array u_tag_array (
        .clk      (clk),
        .rst      (rst),
        .rd_index (rd_index),
        .cmp_tag  (cmp_tag),
        .wr_index (wr_index),
        .wr_way   (wr_way),
        .wr_tag   (wr_tag),
        .way_hit  (way_hit)
    );

    dcache_data_array u_data_array (
        .clk      (clk),
        .rd_index (rd_index),
        .way_hit  (way_hit),
        .wr_index (wr_index),
        .wr_way   (wr_way),
        .wr_strb  (wr_strb),
        .wr_line  (wr_line),
        .hit_line (hit_line)
    );

    dcache_victim_lfsr u_victim_lfsr (
        .clk    (clk),
        .rst    (rst),
        .victim (victim)
    );

endmodule

// ==== dcache_victim_lfsr.sv ====
`include "dcache_config.svh"
`timescale 1ns/10ps

module dcache_victim_lfsr
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output way_mask_t victim
);

    localparam int LW = `DCACHE_LFSR_WIDTH;
    localparam int SEL_W = $clog2(`DCACHE_NWAY);
    localparam logic [LW-1:0] TAPS = 16'hB400;  // x^16+x^14+x^13+x^11+1
    localparam logic [LW-1:0] SEED = 16'hACE1;

    logic [LW-1:0] lfsr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= SEED;
        end else begin
            lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? TAPS : '0);  // galois step
        end
    end

    assign victim = way_mask_t'(1) << lfsr_q[SEL_W-1:0];

endmodule

// ==== mem_bus_pkg.sv ====
`include "dcache_config.svh"

package mem_bus_pkg;

    // transfer size on rd_type / wr_type
    typedef enum logic [2:0] {
        MEM_BYTE = 3'b000,
        MEM_HALF = 3'b001,
        MEM_WORD = 3'b010,
        MEM_LINE = 3'b100
    } mem_type_e;

    // one strobe bit per byte of a bus beat
    typedef logic [`DCACHE_LINE_BYTES-1:0] line_strb_t;

endpackage

// ==== run.sh ====
#!/bin/bash
# compile with Verilator and run, pass decided from the simulation output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module tb_dcache -o tb_dcache_sim &&
./obj_dir/tb_dcache_sim | tee /dev/stderr | grep "all tests passed" > /dev/null &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

// ==== sim.f ====
+incdir+.
mem_bus_pkg.sv
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_victim_lfsr.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

// ==== tb_dcache.sv ====
`include "dcache_config.svh"
`timescale 1ns/10ps

module tb_dcache
    import dcache_pkg::*;
    import mem_bus_pkg::*;
;

    localparam int NUM_REQ = 2000;
    localparam int RST_CYCLES = 16;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_write;
    logic        req_uncached;
    logic [31:0] req_addr;
    logic [3:0]  req_wstrb;
    word_t       req_wdata;
    logic        req_ready;
    logic        resp_valid;
    word_t       resp_rdata;
    logic        rd_req;
    mem_type_e   rd_type;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    line_t       ret_data;
    logic        wr_req;
    mem_type_e   wr_type;
    logic [31:0] wr_addr;
    line_strb_t  wr_wstrb;
    line_t       wr_data;
    logic        wr_rdy;

    integer seed = 32'h8f27;
    integer errors = 0;
    integer cyc = 0;
    integer acc_cyc = 0;
    integer latency = 0;
    integer rd_xfers = 0;
    integer wr_xfers = 0;
    bit     in_flight = 0;
    bit     resp_done = 0;

    // request currently in flight
    bit          cur_write;
    bit          cur_uncached;
    logic [31:0] cur_addr;
    logic [3:0]  cur_wstrb;
    word_t       cur_wdata;
    word_t       exp_rdata;

    // memory model with one word per word address
    word_t mem [int unsigned];

    // memory responder state
    bit          rd_busy = 0;
    bit          wr_busy = 0;
    bit          ret_pend = 0;
    integer      rd_dly = 0;
    integer      wr_dly = 0;
    integer      ret_dly = 0;
    logic [31:0] ret_addr;
    mem_type_e   ret_type;

    dcache_top u_dcache_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h6b3d19c5;
    endfunction

    function automatic word_t model_read(input logic [31:0] a);
        if (mem.exists(a[31:2])) return mem[a[31:2]];
        return fill_word({a[31:2], 2'b00});
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    // bus transfers and responses sampled on the rising edge
    always @(posedge clk) begin
        cyc++;
        if (!rst) begin
            if (rd_req && wr_req) begin
                $display("error: rd_req and wr_req are high in the same cycle");
                errors++;
            end
            if (req_valid && req_ready) begin
                acc_cyc = cyc;
                in_flight = 1;
            end
            if (rd_req && rd_rdy) begin
                rd_xfers++;
                if (cur_uncached) begin
                    check("rd_type", rd_type, MEM_WORD);
                    check("rd_addr", rd_addr, cur_addr);
                end else begin
                    check("rd_type", rd_type, MEM_LINE);
                    check("rd_addr", rd_addr, {cur_addr[31:4], 4'h0});
                end
            end
            if (wr_req && wr_rdy) begin
                word_t w;
                wr_xfers++;
                check("wr_type", wr_type, MEM_WORD);
                check("wr_addr", wr_addr, cur_addr);
                check("wr_wstrb", wr_wstrb, line_strb_t'(cur_wstrb) << (cur_addr[3:2] * 4));
                check("wr_data", wr_data, line_t'(cur_wdata) << (cur_addr[3:2] * 32));
                w = model_read(cur_addr);
                for (int b = 0; b < 4; b++) begin
                    if (cur_wstrb[b]) w[b*8 +: 8] = cur_wdata[b*8 +: 8];
                end
                mem[cur_addr[31:2]] = w;
            end
            if (resp_valid) begin
                if (!in_flight) begin
                    $display("error: response without an accepted request");
                    errors++;
                end
                latency = cyc - acc_cyc;
                if (!cur_write) check("resp_rdata", resp_rdata, exp_rdata);
                resp_done = 1;
                in_flight = 0;
            end
        end
    end

    // memory side driven on the falling edge with random delays
    always @(negedge clk) begin
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        if (!rst) begin
            if (ret_pend) begin  // beat goes out before a new transfer is seen
                if (ret_dly == 0) begin
                    ret_valid = 1'b1;
                    ret_last  = 1'b1;
                    ret_pend  = 0;
                    if (ret_type == MEM_LINE) begin
                        for (int w = 0; w < 4; w++) begin
                            ret_data[w*32 +: 32] = model_read({ret_addr[31:4], w[1:0], 2'b00});
                        end
                    end else begin
                        ret_data = line_t'(model_read(ret_addr)) << (ret_addr[3:2] * 32);
                    end
                end else begin
                    ret_dly--;
                end
            end
            if (rd_req && !rd_busy) begin
                rd_busy = 1;
                rd_dly = $random(seed) & 3;
            end
            if (rd_busy) begin
                if (rd_dly == 0) begin
                    rd_rdy   = 1'b1;  // transfer on the next rising edge
                    rd_busy  = 0;
                    ret_pend = 1;
                    ret_dly  = $random(seed) & 3;
                    ret_addr = rd_addr;
                    ret_type = rd_type;
                end else begin
                    rd_dly--;
                end
            end
            if (wr_req && !wr_busy) begin
                wr_busy = 1;
                wr_dly = $random(seed) & 3;
            end
            if (wr_busy) begin
                if (wr_dly == 0) begin
                    wr_rdy  = 1'b1;
                    wr_busy = 0;
                end else begin
                    wr_dly--;
                end
            end
        end
    end

    initial begin
        #((RST_CYCLES + NUM_REQ * 40) * 10);
        $display("timeout: the run did not finish in time, %0d errors", errors);
        $display("tests failed");
        $finish;
    end

    initial begin
        integer r;
        bit          prev_valid;
        logic [27:0] prev_line;
        logic [19:0] tag;
        logic [7:0]  index;
        rst = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_uncached = 1'b0;
        req_addr = '0;
        req_wstrb = '0;
        req_wdata = '0;
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        wr_rdy = 1'b0;
        prev_valid = 0;
        prev_line = '0;

        repeat (RST_CYCLES) begin
            @(negedge clk);
            check("rd_req", rd_req, 1'b0);
            check("wr_req", wr_req, 1'b0);
            check("resp_valid", resp_valid, 1'b0);
        end
        rst = 1'b0;
        @(negedge clk);
        check("req_ready", req_ready, 1'b1);

        for (int n = 0; n < NUM_REQ; n++) begin
            r = $random(seed);
            cur_write    = (r[1:0] == 2'b00);
            cur_uncached = (r[4:2] == 3'b000);
            tag   = cur_uncached ? 20'hf0000 : 20'h00100 + 20'(r[6:5]);
            index = 8'(r[8:7]) * 8'h45;  // four sets
            cur_addr  = {tag, index, r[10:9], 2'b00};
            cur_wstrb = (r[14:11] == 4'h0) ? 4'hf : r[14:11];
            cur_wdata = $random(seed);
            while (!req_ready) @(negedge clk);
            exp_rdata = model_read(cur_addr);
            rd_xfers  = 0;
            wr_xfers  = 0;
            resp_done = 0;
            req_valid    = 1'b1;
            req_write    = cur_write;
            req_uncached = cur_uncached;
            req_addr     = cur_addr;
            req_wstrb    = cur_wstrb;
            req_wdata    = cur_wdata;
            @(negedge clk);
            req_valid = 1'b0;
            while (!resp_done) @(negedge clk);

            if (cur_write) begin
                check("wr_xfers", wr_xfers, 1);
                check("rd_xfers", rd_xfers, 0);
            end else if (cur_uncached) begin
                check("rd_xfers", rd_xfers, 1);
                check("wr_xfers", wr_xfers, 0);
            end else begin
                if (prev_valid && prev_line == cur_addr[31:4]) begin
                    check("rd_xfers", rd_xfers, 0);
                    check("latency", latency, 1);
                end else if (rd_xfers > 1) begin
                    $display("error: cached read issued %0d line reads", rd_xfers);
                    errors++;
                end
                check("wr_xfers", wr_xfers, 0);
                prev_valid = 1;
                prev_line  = cur_addr[31:4];
            end
        end

        repeat (2) @(negedge clk);
        $display("requests: %0d, errors: %0d", NUM_REQ, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
